/* common/uart_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART settings
// Divider, FIFO sizing, stop bits and
// the register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Clocks per bit minus one
`define UART_DIV_RESET   16
`define UART_FIFO_DEPTH  8
`define UART_COUNT_W     ($clog2(`UART_FIFO_DEPTH + 1))
// 0 is one stop bit, 1 is two
`define UART_NSTOP       1'b0

`define UART_ADDR_TXDATA 3'd0
`define UART_ADDR_RXDATA 3'd1
`define UART_ADDR_TXCTRL 3'd2
`define UART_ADDR_RXCTRL 3'd3
`define UART_ADDR_IE     3'd4
`define UART_ADDR_IP     3'd5
`define UART_ADDR_DIV    3'd6

`endif

/* common/uart_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART echo types
// Data, bus and counter vectors plus the
// echo controller states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package uart_pkg;

  typedef logic [7:0]  uart_byte_t;
  typedef logic [31:0] uart_word_t;
  typedef logic [2:0]  uart_addr_t;
  typedef logic [15:0] uart_div_t;
  // Watermark level
  typedef logic [2:0]  uart_cnt_t;

  typedef enum logic [2:0] {
    idle            = 3'd0,
    conf_rx_ctrl    = 3'd1,
    conf_tx_ctrl    = 3'd2,
    conf_int_en     = 3'd3,
    wait_rx_pending = 3'd4,
    reading         = 3'd5,
    writing         = 3'd6
  } echo_state_t;

endpackage

`default_nettype wire

/* uart/uart_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART byte FIFO
// Circular buffer with level and flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module uart_fifo #(
  parameter int DEPTH = 8
) (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        push,
  input  wire uart_pkg::uart_byte_t  push_data,
  input  wire                        pop,
  output uart_pkg::uart_byte_t       pop_data,
  output logic [$clog2(DEPTH+1)-1:0] count,
  output logic                       full,
  output logic                       empty
);
  import uart_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  uart_byte_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign full     = (count == DEPTH);
  assign empty    = (count == 0);
  assign do_pop   = pop && !empty;
  // A full FIFO still takes a push when it pops in the same cycle
  assign do_push  = push && (!full || do_pop);
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART transmitter
// Sends 8N1 or 8N2 frames from the FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module uart_tx (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       enable,
  input  wire                       nstop,
  input  wire uart_pkg::uart_div_t  div,
  input  wire                       fifo_empty,
  input  wire uart_pkg::uart_byte_t fifo_data,
  output logic                      fifo_pop,
  output logic                      txd
);
  import uart_pkg::*;

  uart_div_t   div_cnt;
  logic [3:0]  bits_left;
  // Stop bits, data LSB first, start bit at the bottom
  logic [10:0] shreg;
  logic        busy;

  assign fifo_pop = enable && !busy && !fifo_empty;
  assign txd      = shreg[0];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      div_cnt   <= '0;
      bits_left <= '0;
      shreg     <= '1;
      busy      <= 1'b0;
    end else if (fifo_pop) begin
      busy      <= 1'b1;
      div_cnt   <= '0;
      bits_left <= nstop ? 4'd11 : 4'd10;
      shreg     <= {2'b11, fifo_data, 1'b0};
    end else if (busy) begin
      if (div_cnt == div) begin
        div_cnt   <= '0;
        // Line idles high once everything is shifted out
        shreg     <= {1'b1, shreg[10:1]};
        bits_left <= bits_left - 1'b1;
        if (bits_left == 4'd1) busy <= 1'b0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART receiver
// Mid-bit sampling with a stop bit check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module uart_rx (
  input  wire                      clock,
  input  wire                      reset,
  input  wire                      enable,
  input  wire uart_pkg::uart_div_t div,
  input  wire                      rxd,
  output logic                     rx_valid,
  output uart_pkg::uart_byte_t     rx_byte
);
  import uart_pkg::*;

  uart_div_t  div_cnt;
  // 0 start, 1 to 8 data, 9 stop
  logic [3:0] bit_idx;
  logic       busy;
  logic       rxd_meta;
  logic       rxd_sync;
  logic       rxd_prev;
  logic       sample;
  logic       bit_end;

  assign sample  = busy && (div_cnt == (div >> 1));
  assign bit_end = busy && (div_cnt == div);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
      busy     <= 1'b0;
      div_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
      rx_valid <= 1'b0;
      if (!busy) begin
        // Falling edge opens a frame
        if (enable && rxd_prev && !rxd_sync) begin
          busy    <= 1'b1;
          div_cnt <= '0;
          bit_idx <= '0;
        end
      end else begin
        if (bit_end) begin
          div_cnt <= '0;
          bit_idx <= bit_idx + 1'b1;
        end else begin
          div_cnt <= div_cnt + 1'b1;
        end
        if (sample) begin
          if (bit_idx == 4'd0 && rxd_sync) begin
            // Glitch, not a real start bit
            busy <= 1'b0;
          end else if (bit_idx == 4'd9) begin
            rx_valid <= rxd_sync;
            busy     <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) rx_byte <= {rxd_sync, rx_byte[7:1]};
  end

endmodule

`default_nettype wire

/* uart/uart_bus_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART register block
// Bus slave for control, interrupt and
// FIFO data registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "uart_defines.svh"

module uart_bus_regs (
  input  wire                          clock,
  input  wire                          reset,
  input  wire                          cyc,
  input  wire                          stb,
  input  wire                          we,
  input  wire uart_pkg::uart_addr_t    addr,
  input  wire uart_pkg::uart_word_t    wr_data,
  output uart_pkg::uart_word_t         rd_data,
  output logic                         ack,
  output logic                         irq,
  output logic                         tx_push,
  output uart_pkg::uart_byte_t         tx_push_data,
  input  wire                          tx_full,
  input  wire [`UART_COUNT_W-1:0]      tx_count,
  output logic                         rx_pop,
  input  wire uart_pkg::uart_byte_t    rx_data,
  input  wire                          rx_empty,
  input  wire [`UART_COUNT_W-1:0]      rx_count,
  output logic                         tx_en,
  output logic                         rx_en,
  output logic                         nstop,
  output uart_pkg::uart_div_t          div
);
  import uart_pkg::*;

  typedef logic [`UART_COUNT_W-1:0] count_t;

  logic       access;
  uart_cnt_t  tx_wm;
  uart_cnt_t  rx_wm;
  // Bit 0 txwm, bit 1 rxwm
  logic [1:0] ie;
  logic [1:0] ip;
  uart_word_t rd_mux;

  // First cycle of a request; ack follows one cycle later
  assign access = cyc && stb && !ack;

  assign div          = uart_div_t'(`UART_DIV_RESET);
  assign tx_push      = access && we && (addr == `UART_ADDR_TXDATA);
  assign tx_push_data = wr_data[7:0];
  assign rx_pop       = access && !we && (addr == `UART_ADDR_RXDATA) && !rx_empty;

  assign ip[0] = tx_count < count_t'(tx_wm);
  assign ip[1] = rx_count > count_t'(rx_wm);
  assign irq   = |(ip & ie);

  always_comb begin
    rd_mux = '0;
    case (addr)
      `UART_ADDR_TXDATA: rd_mux[31] = tx_full;
      `UART_ADDR_RXDATA: rd_mux = {rx_empty, 23'd0, rx_data};
      `UART_ADDR_TXCTRL: rd_mux = {13'd0, tx_wm, 14'd0, nstop, tx_en};
      `UART_ADDR_RXCTRL: rd_mux = {13'd0, rx_wm, 15'd0, rx_en};
      `UART_ADDR_IE:     rd_mux[1:0] = ie;
      `UART_ADDR_IP:     rd_mux[1:0] = ip;
      `UART_ADDR_DIV:    rd_mux[15:0] = div;
      default:           rd_mux = '0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack   <= 1'b0;
      tx_en <= 1'b0;
      nstop <= 1'b0;
      tx_wm <= '0;
      rx_en <= 1'b0;
      rx_wm <= '0;
      ie    <= '0;
    end else begin
      ack <= access;
      if (access && we) begin
        case (addr)
          `UART_ADDR_TXCTRL: begin
            tx_en <= wr_data[0];
            nstop <= wr_data[1];
            tx_wm <= wr_data[18:16];
          end
          `UART_ADDR_RXCTRL: begin
            rx_en <= wr_data[0];
            rx_wm <= wr_data[18:16];
          end
          `UART_ADDR_IE: ie <= wr_data[1:0];
          default: ie <= ie;
        endcase
      end
    end
  end

  // Read data lands with the ack
  always_ff @(posedge clock) begin
    if (access && !we) rd_data <= rd_mux;
  end

endmodule

`default_nettype wire

/* uart/uart.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART
// Registers, FIFOs and serial engines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "uart_defines.svh"

module uart (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       cyc,
  input  wire                       stb,
  input  wire                       we,
  input  wire uart_pkg::uart_addr_t addr,
  input  wire uart_pkg::uart_word_t wr_data,
  input  wire                       rxd,
  output uart_pkg::uart_word_t      rd_data,
  output logic                      ack,
  output logic                      irq,
  output logic                      txd
);
  import uart_pkg::*;

  logic                     tx_push;
  uart_byte_t               tx_push_data;
  logic                     tx_pop;
  uart_byte_t               tx_pop_data;
  logic [`UART_COUNT_W-1:0] tx_count;
  logic                     tx_full;
  logic                     tx_empty;
  logic                     rx_valid;
  uart_byte_t               rx_byte;
  logic                     rx_pop;
  uart_byte_t               rx_pop_data;
  logic [`UART_COUNT_W-1:0] rx_count;
  logic                     rx_empty;
  logic                     tx_en;
  logic                     rx_en;
  logic                     nstop;
  uart_div_t                div;

  uart_bus_regs u_regs (
    .clock        (clock),
    .reset        (reset),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .addr         (addr),
    .wr_data      (wr_data),
    .rd_data      (rd_data),
    .ack          (ack),
    .irq          (irq),
    .tx_push      (tx_push),
    .tx_push_data (tx_push_data),
    .tx_full      (tx_full),
    .tx_count     (tx_count),
    .rx_pop       (rx_pop),
    .rx_data      (rx_pop_data),
    .rx_empty     (rx_empty),
    .rx_count     (rx_count),
    .tx_en        (tx_en),
    .rx_en        (rx_en),
    .nstop        (nstop),
    .div          (div)
  );

  uart_fifo #(
    .DEPTH (`UART_FIFO_DEPTH)
  ) u_tx_fifo (
    .clock     (clock),
    .reset     (reset),
    .push      (tx_push),
    .push_data (tx_push_data),
    .pop       (tx_pop),
    .pop_data  (tx_pop_data),
    .count     (tx_count),
    .full      (tx_full),
    .empty     (tx_empty)
  );

  // Received bytes go straight in, dropped when full
  uart_fifo #(
    .DEPTH (`UART_FIFO_DEPTH)
  ) u_rx_fifo (
    .clock     (clock),
    .reset     (reset),
    .push      (rx_valid),
    .push_data (rx_byte),
    .pop       (rx_pop),
    .pop_data  (rx_pop_data),
    .count     (rx_count),
    .full      (),
    .empty     (rx_empty)
  );

  uart_tx u_tx (
    .clock      (clock),
    .reset      (reset),
    .enable     (tx_en),
    .nstop      (nstop),
    .div        (div),
    .fifo_empty (tx_empty),
    .fifo_data  (tx_pop_data),
    .fifo_pop   (tx_pop),
    .txd        (txd)
  );

  uart_rx u_rx (
    .clock    (clock),
    .reset    (reset),
    .enable   (rx_en),
    .div      (div),
    .rxd      (rxd),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

endmodule

`default_nettype wire

/* src/echo_controller.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Echo controller
// Sets up the UART over the bus, then
// writes back every received byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "uart_defines.svh"

module echo_controller (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       ack,
  input  wire                       irq,
  input  wire uart_pkg::uart_word_t rd_data,
  output logic                      cyc,
  output logic                      stb,
  output logic                      we,
  output uart_pkg::uart_addr_t      addr,
  output uart_pkg::uart_word_t      wr_data
);
  import uart_pkg::*;

  echo_state_t state;
  echo_state_t next_state;
  uart_byte_t  echo_byte;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) state <= idle;
    else state <= next_state;
  end

  always_ff @(posedge clock) begin
    if (state == reading && ack) echo_byte <= rd_data[7:0];
  end

  always_comb begin
    next_state = state;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wr_data    = '0;
    case (state)
      idle: next_state = conf_rx_ctrl;
      conf_rx_ctrl: begin
        {cyc, stb, we} = 3'b111;
        addr           = `UART_ADDR_RXCTRL;
        wr_data[0]     = 1'b1;
        wr_data[18:16] = 3'd0;
        if (ack) next_state = conf_tx_ctrl;
      end
      conf_tx_ctrl: begin
        {cyc, stb, we} = 3'b111;
        addr           = `UART_ADDR_TXCTRL;
        wr_data[0]     = 1'b1;
        wr_data[1]     = `UART_NSTOP;
        wr_data[18:16] = 3'd2;
        if (ack) next_state = conf_int_en;
      end
      conf_int_en: begin
        {cyc, stb, we} = 3'b111;
        addr           = `UART_ADDR_IE;
        // Receive watermark only
        wr_data[1]     = 1'b1;
        if (ack) next_state = wait_rx_pending;
      end
      wait_rx_pending: begin
        if (irq) next_state = reading;
      end
      reading: begin
        {cyc, stb} = 2'b11;
        addr       = `UART_ADDR_RXDATA;
        if (ack) next_state = writing;
      end
      writing: begin
        {cyc, stb, we} = 3'b111;
        addr           = `UART_ADDR_TXDATA;
        wr_data[7:0]   = echo_byte;
        if (ack) next_state = wait_rx_pending;
      end
      default: next_state = idle;
    endcase
  end

endmodule

`default_nettype wire

/* src/uart_echo_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART echo top
// Echo controller driving the UART bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module uart_echo_top (
  input  wire  clock,
  input  wire  reset,
  input  wire  rxd,
  output logic txd
);
  import uart_pkg::*;

  wire             cyc;
  wire             stb;
  wire             we;
  wire uart_addr_t addr;
  wire uart_word_t wr_data;
  wire uart_word_t rd_data;
  wire             ack;
  wire             irq;

  echo_controller u_ctrl (
    .clock   (clock),
    .reset   (reset),
    .ack     (ack),
    .irq     (irq),
    .rd_data (rd_data),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .addr    (addr),
    .wr_data (wr_data)
  );

  uart u_uart (
    .clock   (clock),
    .reset   (reset),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .addr    (addr),
    .wr_data (wr_data),
    .rxd     (rxd),
    .rd_data (rd_data),
    .ack     (ack),
    .irq     (irq),
    .txd     (txd)
  );

endmodule

`default_nettype wire

/* tests/uart_echo_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART echo assertions
// Bus ack spacing and FIFO flag sanity,
// bound into the register block and FIFOs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module uart_echo_asserts (
  input wire clock,
  input wire reset,
  input wire ack,
  input wire full,
  input wire empty
);

  // Number of assertion failures in this instance
  int unsigned fail_count = 0;

  // Ack is a single-cycle pulse
  ack_single_cycle: assert property (
    @(posedge clock) disable iff (reset) ack |=> !ack
  ) else begin
    fail_count++;
    $error("ack was high in two consecutive cycles");
  end

  fifo_flags_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(full && empty)
  ) else begin
    fail_count++;
    $error("FIFO reports full and empty at once");
  end

endmodule

`default_nettype wire

/* tests/uart_echo_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART echo testbench
// Drives serial frames into the echo top
// and checks every frame sent back on txd
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "uart_defines.svh"

module uart_echo_tb;
  import uart_pkg::*;

  localparam int BIT_CLOCKS = `UART_DIV_RESET + 1;
  localparam int ECHO_TIMEOUT_BITS = 40;

  logic        clock;
  logic        reset;
  logic        rxd;
  wire         txd;
  int          errors;
  int          checks;
  logic [31:0] rand_state;

  uart_echo_top uut (
    .clock (clock),
    .reset (reset),
    .rxd   (rxd),
    .txd   (txd)
  );

  bind uart_bus_regs uart_echo_asserts u_bus_asserts (
    .clock (clock), .reset (reset), .ack (ack), .full (1'b0), .empty (1'b0)
  );
  bind uart_fifo uart_echo_asserts u_fifo_asserts (
    .clock (clock), .reset (reset), .ack (1'b0), .full (full), .empty (empty)
  );

  always #10 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  // One bit on rxd, starting and ending on a falling edge
  task automatic drive_bit(input logic value);
    rxd = value;
    repeat (BIT_CLOCKS) @(negedge clock);
  endtask

  task automatic send_frame(input uart_byte_t data, input logic stop_bit);
    @(negedge clock);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(data[i]);
    drive_bit(stop_bit);
    // Return the line to idle after a broken stop bit
    if (!stop_bit) drive_bit(1'b1);
  endtask

  task automatic receive_frame(output uart_byte_t data, output logic stop_bit,
                               output logic found, input int max_bits);
    int waited;
    found    = 1'b0;
    data     = '0;
    stop_bit = 1'b0;
    waited   = 0;
    while (!found && waited < max_bits * BIT_CLOCKS) begin
      @(negedge clock);
      waited++;
      if (txd === 1'b0) found = 1'b1;
    end
    if (!found) return;
    // Move to the middle of the start bit
    repeat (BIT_CLOCKS / 2) @(negedge clock);
    check_value("txd start bit", txd, 32'h0);
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLOCKS) @(negedge clock);
      data[i] = txd;
    end
    repeat (BIT_CLOCKS) @(negedge clock);
    stop_bit = txd;
  endtask

  task automatic count_low_cycles(input int bits, output int lows);
    lows = 0;
    repeat (bits * BIT_CLOCKS) begin
      @(negedge clock);
      if (txd !== 1'b1) lows++;
    end
  endtask

  // Next frame on txd must carry the byte sent
  task automatic expect_echo(input uart_byte_t value, input string label);
    uart_byte_t got;
    logic       stop_bit;
    logic       found;
    receive_frame(got, stop_bit, found, ECHO_TIMEOUT_BITS);
    if (!found) begin
      errors++;
      $display("%s: no echo frame appeared on txd for byte 0x%02h", label, value);
    end else begin
      check_value({label, " data"}, got, value);
      check_value({label, " stop bit"}, stop_bit, 32'h1);
    end
  endtask

  task automatic echo_one(input uart_byte_t value, input string label);
    fork
      send_frame(value, 1'b1);
      expect_echo(value, label);
    join
  endtask

  task automatic test_idle_after_reset();
    int lows;
    count_low_cycles(20, lows);
    check_value("txd low cycles after reset", lows, 32'h0);
  endtask

  task automatic test_single_byte();
    echo_one(8'hA5, "single byte");
  endtask

  task automatic test_burst();
    uart_byte_t sent [8];
    for (int i = 0; i < 8; i++) begin
      rand_state = xorshift32(rand_state);
      sent[i]    = rand_state[7:0];
    end
    fork
      begin
        for (int i = 0; i < 8; i++) send_frame(sent[i], 1'b1);
      end
      begin
        for (int i = 0; i < 8; i++) begin
          expect_echo(sent[i], $sformatf("burst byte %0d", i));
        end
      end
    join
  endtask

  task automatic test_framing_error();
    int lows;
    fork
      send_frame(8'h3C, 1'b0);
      count_low_cycles(41, lows);
    join
    check_value("txd low cycles after framing error", lows, 32'h0);
    echo_one(8'h5A, "after framing error");
  endtask

  task automatic test_edge_bytes();
    echo_one(8'h00, "byte 0x00");
    echo_one(8'hFF, "byte 0xff");
  endtask

  initial begin
    clock      = 1'b0;
    reset      = 1'b1;
    rxd        = 1'b1;
    errors     = 0;
    checks     = 0;
    rand_state = 32'ha637;
    repeat (3) @(negedge clock);
    reset = 1'b0;

    test_idle_after_reset();
    test_single_byte();
    test_burst();
    test_framing_error();
    test_edge_bytes();

    errors += uut.u_uart.u_regs.u_bus_asserts.fail_count;
    errors += uut.u_uart.u_tx_fifo.u_fifo_asserts.fail_count;
    errors += uut.u_uart.u_rx_fifo.u_fifo_asserts.fail_count;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/uart_pkg.sv
uart/uart_fifo.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_bus_regs.sv
uart/uart.sv
src/echo_controller.sv
src/uart_echo_top.sv
tests/uart_echo_asserts.sv
tests/uart_echo_tb.sv

/* Bender.yml */
package:
  name: uart_echo

sources:
  - include_dirs:
      - common
    files:
      - common/uart_pkg.sv
      - uart/uart_fifo.sv
      - uart/uart_tx.sv
      - uart/uart_rx.sv
      - uart/uart_bus_regs.sv
      - uart/uart.sv
      - src/echo_controller.sv
      - src/uart_echo_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/uart_echo_asserts.sv
      - tests/uart_echo_tb.sv
